// File: mem_subsys.f
verilog/mem_pkg.sv
verilog/mem_stage.sv
verilog/data_ram.sv
verilog/debug_port.sv
verilog/reg_file.sv
verilog/mem_subsys.sv
bench/mem_subsys_tb.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  - verilog/mem_pkg.sv
  - verilog/mem_stage.sv
  - verilog/data_ram.sv
  - verilog/debug_port.sv
  - verilog/reg_file.sv
  - verilog/mem_subsys.sv
  - target: test
    files:
      - bench/mem_subsys_tb.sv

// File: bench/mem_subsys_tb.sv
`timescale 1ns/1ps

module mem_subsys_tb import mem_pkg::*; ();

	localparam int icache_idx_bits = 6;
	localparam int ram_words       = 256;
	localparam int wait_states     = 2;
	localparam int timeout_cycles  = 20;

	logic                       clk = 1'b0;
	logic                       rst;
	logic                       load;
	logic                       store;
	logic [data_width-1:0]      addr;
	logic [data_width-1:0]      mdr;
	logic                       mem_wr_en;
	logic [1:0]                 width;
	logic [data_width-1:0]      wr_val;
	logic                       update_rd;
	logic [3:0]                 rd_sel;
	logic                       cache_instr;
	logic [1:0]                 cache_op;
	logic                       dbg_req;
	logic                       dbg_wr;
	logic [data_width-1:0]      dbg_addr;
	logic [1:0]                 dbg_width;
	logic [data_width-1:0]      dbg_wdata;
	logic [3:0]                 rf_sel;
	logic                       complete;
	logic                       data_abort;
	logic                       busy;
	logic                       i_inval;
	logic [icache_idx_bits-1:0] i_idx;
	logic                       dbg_ack;
	logic [data_width-1:0]      dbg_rdata;
	logic [data_width-1:0]      rf_val;

	logic [7:0]  ram_model [ram_words*4]; // Byte-addressed, little endian.
	logic [31:0] reg_model [16];
	int          checks_done = 0;

	always #20 clk = ~clk;

	mem_subsys #(
		.icache_idx_bits(icache_idx_bits),
		.ram_words(ram_words),
		.wait_states(wait_states)
	) u_mem_subsys (
		.clk(clk), .rst(rst), .load(load), .store(store), .addr(addr), .mdr(mdr),
		.mem_wr_en(mem_wr_en), .width(width), .wr_val(wr_val), .update_rd(update_rd),
		.rd_sel(rd_sel), .cache_instr(cache_instr), .cache_op(cache_op),
		.dbg_req(dbg_req), .dbg_wr(dbg_wr), .dbg_addr(dbg_addr), .dbg_width(dbg_width),
		.dbg_wdata(dbg_wdata), .rf_sel(rf_sel), .complete(complete),
		.data_abort(data_abort), .busy(busy), .i_inval(i_inval), .i_idx(i_idx),
		.dbg_ack(dbg_ack), .dbg_rdata(dbg_rdata), .rf_val(rf_val)
	);

	task automatic stop_on_mismatch(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic expect_equal(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks_done++;
		assert (got === exp)
		else stop_on_mismatch($sformatf("%s got %08h expected %08h", what, got, exp));
	endtask

	function automatic bit in_range(input logic [31:0] a);
		return (a >> 2) < ram_words;
	endfunction

	function automatic logic [31:0] fill_pattern(input int w);
		return (32'h9e37_79b9 * (w + 1)) ^ (w << 16);
	endfunction

	// Expected load value with the lane moved down and zero fill.
	function automatic logic [31:0] model_read(input logic [31:0] a, input logic [1:0] w);
		logic [31:0] b;
		case (w)
		width_byte: return {24'b0, ram_model[a]};
		width_half: begin
			b = {a[31:1], 1'b0};
			return {16'b0, ram_model[b + 1], ram_model[b]};
		end
		default: begin
			b = {a[31:2], 2'b00};
			return {ram_model[b + 3], ram_model[b + 2], ram_model[b + 1], ram_model[b]};
		end
		endcase
	endfunction

	function automatic void model_write(input logic [31:0] a, input logic [1:0] w,
			input logic [31:0] data);
		logic [31:0] b;
		case (w)
		width_byte: ram_model[a] = data[7:0];
		width_half: begin
			b = {a[31:1], 1'b0};
			ram_model[b]     = data[7:0];
			ram_model[b + 1] = data[15:8];
		end
		default: begin
			b = {a[31:2], 2'b00};
			for (int i = 0; i < 4; i++)
				ram_model[b + i] = data[8*i +: 8];
		end
		endcase
	endfunction

	// Holds the request until complete, then releases it a cycle later.
	task automatic mem_access(input bit is_store, input logic [31:0] a, input logic [1:0] w,
			input logic [31:0] data, input logic [3:0] rd, output bit abort);
		int cycles;
		@(negedge clk);
		load      = !is_store;
		store     = is_store;
		mem_wr_en = is_store;
		addr      = a;
		width     = w;
		mdr       = data;
		rd_sel    = rd;
		cycles    = 1;
		@(negedge clk);
		while (!complete && cycles < timeout_cycles) begin
			@(negedge clk);
			cycles++;
		end
		if (!complete)
			stop_on_error("timed out waiting for complete on a load or store");
		expect_equal("memory access latency", cycles, wait_states + 1);
		abort = data_abort;
		@(negedge clk); // Writeback edge has passed.
		load      = 1'b0;
		store     = 1'b0;
		mem_wr_en = 1'b0;
	endtask

	task automatic check_reg(input logic [3:0] rd);
		@(negedge clk);
		rf_sel = rd;
		@(negedge clk);
		expect_equal($sformatf("register r%0d", rd), rf_val, reg_model[rd]);
	endtask

	task automatic do_store(input logic [31:0] a, input logic [1:0] w, input logic [31:0] data);
		bit abort;
		mem_access(1'b1, a, w, data, 4'd0, abort);
		expect_equal("store abort flag", abort, !in_range(a));
		if (in_range(a))
			model_write(a, w, data);
	endtask

	task automatic do_load(input logic [31:0] a, input logic [1:0] w, input logic [3:0] rd);
		bit abort;
		mem_access(1'b0, a, w, $urandom, rd, abort);
		expect_equal("load abort flag", abort, !in_range(a));
		if (in_range(a))
			reg_model[rd] = model_read(a, w); // Aborted loads leave rd alone.
		check_reg(rd);
	endtask

	task automatic reg_write(input logic [3:0] rd, input logic [31:0] val);
		@(negedge clk);
		update_rd = 1'b1;
		rd_sel    = rd;
		wr_val    = val;
		@(negedge clk);
		update_rd = 1'b0;
		reg_model[rd] = val;
	endtask

	task automatic cache_run(input logic [1:0] op, input logic [31:0] a);
		@(negedge clk);
		cache_instr = 1'b1;
		cache_op    = op;
		addr        = a;
		@(negedge clk);
		expect_equal("complete after cache_instr", complete, 1'b1);
		expect_equal("i_inval", i_inval, op == cache_op_inval);
		if (op == cache_op_inval)
			expect_equal("i_idx", i_idx, a[icache_idx_bits-1:0]);
		cache_instr = 1'b0;
		@(negedge clk);
		expect_equal("complete one cycle only", complete, 1'b0);
	endtask

	task automatic debug_xfer(input bit wr, input logic [31:0] a, input logic [1:0] w,
			input logic [31:0] data);
		int cycles;
		@(negedge clk);
		dbg_wr    = wr;
		dbg_addr  = a;
		dbg_width = w;
		dbg_wdata = data;
		dbg_req   = 1'b1;
		cycles    = 0;
		while (!dbg_ack && cycles < wait_states + 3) begin
			@(negedge clk);
			cycles++;
		end
		if (!dbg_ack)
			stop_on_error("dbg_ack did not rise in time after dbg_req");
		if (wr)
			model_write(a, w, data);
		else
			expect_equal("debug read data", dbg_rdata, model_read(a, w));
		@(negedge clk); // Ack must stay up while req is held.
		dbg_req = 1'b0;
		cycles  = 0;
		while (dbg_ack && cycles < timeout_cycles) begin
			@(negedge clk);
			cycles++;
		end
		if (dbg_ack)
			stop_on_error("dbg_ack stayed high after dbg_req fell");
	endtask

	a_inval_hit: assert property (@(posedge clk) disable iff (rst)
		cache_instr && cache_op == cache_op_inval |->
			i_inval && i_idx == addr[icache_idx_bits-1:0])
		else stop_on_mismatch("i_inval or i_idx wrong during an invalidate");

	a_inval_none: assert property (@(posedge clk) disable iff (rst)
		!(cache_instr && cache_op == cache_op_inval) |-> !i_inval)
		else stop_on_mismatch("i_inval high without an invalidate");

	a_cache_start: assert property (@(posedge clk) disable iff (rst)
		$rose(cache_instr) |-> !complete)
		else stop_on_mismatch("complete raised in the cache_instr cycle");

	a_cache_done: assert property (@(posedge clk) disable iff (rst)
		$fell(cache_instr) |-> complete ##1 !complete)
		else stop_on_mismatch("cache op complete not exactly one cycle later");

	a_abort_complete: assert property (@(posedge clk) disable iff (rst)
		data_abort |-> complete)
		else stop_on_mismatch("data_abort without complete");

	a_busy: assert property (@(posedge clk) disable iff (rst)
		(load || store) |-> busy)
		else stop_on_mismatch("busy low while a memory access is pending");

	a_ack_req: assert property (@(posedge clk) disable iff (rst)
		$rose(dbg_ack) |-> dbg_req)
		else stop_on_mismatch("dbg_ack rose without dbg_req");

	a_ack_hold: assert property (@(posedge clk) disable iff (rst)
		dbg_ack && dbg_req |=> dbg_ack)
		else stop_on_mismatch("dbg_ack dropped while dbg_req held");

	a_ack_release: assert property (@(posedge clk) disable iff (rst)
		$fell(dbg_ack) |-> !$past(dbg_req))
		else stop_on_mismatch("dbg_ack fell before dbg_req fell");

	initial begin
		logic [31:0] base;
		logic [31:0] a;
		logic [31:0] v;
		int          k;
		void'($urandom(37));
		rst         = 1'b1;
		load        = 1'b0;
		store       = 1'b0;
		addr        = '0;
		mdr         = '0;
		mem_wr_en   = 1'b0;
		width       = width_word;
		wr_val      = '0;
		update_rd   = 1'b0;
		rd_sel      = '0;
		cache_instr = 1'b0;
		cache_op    = '0;
		dbg_req     = 1'b0;
		dbg_wr      = 1'b0;
		dbg_addr    = '0;
		dbg_width   = width_word;
		dbg_wdata   = '0;
		rf_sel      = '0;
		for (int i = 0; i < 16; i++)
			reg_model[i] = '0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		expect_equal("complete after reset", complete, 1'b0);
		expect_equal("busy after reset", busy, 1'b0);
		expect_equal("dbg_ack after reset", dbg_ack, 1'b0);

		for (int w = 0; w < ram_words; w++)
			do_store(w * 4, width_word, fill_pattern(w));

		// Word store then word load.
		repeat (4) begin
			a = ($urandom % ram_words) * 4;
			do_store(a, width_word, $urandom);
			do_load(a, width_word, 1 + $urandom % 15);
		end

		// Lanes.
		repeat (6) begin
			base = ($urandom % ram_words) * 4;
			for (int off = 0; off < 4; off++)
				do_store(base + off, width_byte, $urandom);
			for (int off = 0; off < 4; off++)
				do_load(base + off, width_byte, 1 + off);
			do_load(base, width_word, 7);
			for (int off = 0; off < 4; off += 2)
				do_store(base + off, width_half, $urandom);
			for (int off = 0; off < 4; off += 2)
				do_load(base + off, width_half, 8 + off / 2);
			do_load(base + 1, width_byte, 10);
			do_load(base, width_word, 11);
		end

		// Register-only writeback, then a load to another register.
		reg_write(5, $urandom);
		check_reg(5);
		reg_write(5, $urandom);
		do_load(($urandom % ram_words) * 4, width_word, 6);
		check_reg(5);

		// Out of range; word k is the alias inside the RAM.
		k = $urandom % ram_words;
		a = (ram_words + k) * 4;
		do_store(a, width_word, $urandom);
		do_load(k * 4, width_word, 9);
		reg_write(12, $urandom);
		do_load(a, width_word, 12);
		do_load(a + 2, width_byte, 12);

		// Debug transfers.
		a = ($urandom % ram_words) * 4;
		debug_xfer(1'b1, a, width_word, $urandom);
		do_load(a, width_word, 13);
		debug_xfer(1'b1, a + 3, width_byte, $urandom);
		do_load(a, width_word, 13);
		a = ($urandom % ram_words) * 4;
		v = $urandom;
		do_store(a, width_word, v);
		debug_xfer(1'b0, a, width_word, 32'h0);
		debug_xfer(1'b0, a + 2, width_half, 32'h0);
		debug_xfer(1'b0, a + 1, width_byte, 32'h0);

		// Cache ops.
		cache_run(cache_op_inval, $urandom);
		cache_run(2'd1, $urandom);
		cache_run(cache_op_inval, $urandom);
		cache_run(2'd3, $urandom);

		if (checks_done > 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("no checks were run");
			$display("TEST FAILED");
			$fatal(1, "no checks were run");
		end
	end

endmodule

// File: verilog/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys import mem_pkg::*; #(
	parameter int icache_idx_bits = 6,
	parameter int ram_words       = 256,
	parameter int wait_states     = 2
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       load,
	input  logic                       store,
	input  logic [data_width-1:0]      addr,
	input  logic [data_width-1:0]      mdr,
	input  logic                       mem_wr_en,
	input  logic [1:0]                 width,
	input  logic [data_width-1:0]      wr_val,
	input  logic                       update_rd,
	input  logic [3:0]                 rd_sel,
	input  logic                       cache_instr,
	input  logic [1:0]                 cache_op,
	input  logic                       dbg_req,
	input  logic                       dbg_wr,
	input  logic [data_width-1:0]      dbg_addr,
	input  logic [1:0]                 dbg_width,
	input  logic [data_width-1:0]      dbg_wdata,
	input  logic [3:0]                 rf_sel,
	output logic                       complete,
	output logic                       data_abort,
	output logic                       busy,
	output logic                       i_inval,
	output logic [icache_idx_bits-1:0] i_idx,
	output logic                       dbg_ack,
	output logic [data_width-1:0]      dbg_rdata,
	output logic [data_width-1:0]      rf_val
);

	// Writeback.
	logic [data_width-1:0] reg_wr_val;
	logic                  update_rd_out;
	logic [3:0]            rd_sel_out;

	// Data bus.
	logic [data_width-3:0] d_addr;
	logic [3:0]            d_bytesel;
	logic                  d_wr_en;
	logic [data_width-1:0] d_wr_val;
	logic                  d_access;
	logic [data_width-1:0] d_data;
	logic                  d_ack;
	logic                  d_error;

	// Debug access path into the stage.
	logic                  dbg_en;
	logic                  dbg_access;
	logic                  dbg_wr_en;
	logic [data_width-1:0] dbg_addr_out;
	logic [1:0]            dbg_width_out;
	logic [data_width-1:0] dbg_wr_val;
	logic [data_width-1:0] dbg_rd_val;
	logic                  dbg_compl;

	mem_stage #(
		.icache_idx_bits(icache_idx_bits)
	) u_mem_stage (
		.clk(clk),
		.rst(rst),
		.load(load),
		.store(store),
		.addr(addr),
		.mdr(mdr),
		.mem_wr_en(mem_wr_en),
		.width(width),
		.wr_val(wr_val),
		.update_rd(update_rd),
		.rd_sel(rd_sel),
		.dbg_en(dbg_en),
		.dbg_access(dbg_access),
		.dbg_wr_en(dbg_wr_en),
		.dbg_addr(dbg_addr_out),
		.dbg_width(dbg_width_out),
		.dbg_wr_val(dbg_wr_val),
		.cache_instr(cache_instr),
		.cache_op(cache_op),
		.d_data(d_data),
		.d_ack(d_ack),
		.d_error(d_error),
		.reg_wr_val(reg_wr_val),
		.update_rd_out(update_rd_out),
		.rd_sel_out(rd_sel_out),
		.complete(complete),
		.data_abort(data_abort),
		.d_addr(d_addr),
		.d_bytesel(d_bytesel),
		.d_wr_en(d_wr_en),
		.d_wr_val(d_wr_val),
		.d_access(d_access),
		.dbg_rd_val(dbg_rd_val),
		.dbg_compl(dbg_compl),
		.busy(busy),
		.i_inval(i_inval),
		.i_idx(i_idx)
	);

	data_ram #(
		.ram_words(ram_words),
		.wait_states(wait_states)
	) u_data_ram (
		.clk(clk),
		.rst(rst),
		.d_addr(d_addr),
		.d_bytesel(d_bytesel),
		.d_wr_en(d_wr_en),
		.d_wr_val(d_wr_val),
		.d_access(d_access),
		.d_data(d_data),
		.d_ack(d_ack),
		.d_error(d_error)
	);

	debug_port u_debug_port (
		.clk(clk),
		.rst(rst),
		.dbg_req(dbg_req),
		.dbg_wr(dbg_wr),
		.dbg_addr(dbg_addr),
		.dbg_width(dbg_width),
		.dbg_wdata(dbg_wdata),
		.dbg_rd_val(dbg_rd_val),
		.dbg_compl(dbg_compl),
		.dbg_ack(dbg_ack),
		.dbg_rdata(dbg_rdata),
		.dbg_en(dbg_en),
		.dbg_access(dbg_access),
		.dbg_wr_en(dbg_wr_en),
		.dbg_addr_out(dbg_addr_out),
		.dbg_width_out(dbg_width_out),
		.dbg_wr_val(dbg_wr_val)
	);

	reg_file u_reg_file (
		.clk(clk),
		.rst(rst),
		.wr_en(update_rd_out),
		.wr_sel(rd_sel_out),
		.wr_val(reg_wr_val),
		.rd_sel(rf_sel),
		.rd_val(rf_val)
	);

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file import mem_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  wr_en,
	input  logic [3:0]            wr_sel,
	input  logic [data_width-1:0] wr_val,
	input  logic [3:0]            rd_sel,
	output logic [data_width-1:0] rd_val
);

	logic [data_width-1:0] regs [16];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_sel] <= wr_val;
		end
	end

	assign rd_val = regs[rd_sel]; // No write-through.

endmodule

// File: verilog/debug_port.sv
`timescale 1ns/1ps

module debug_port import mem_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  dbg_req,
	input  logic                  dbg_wr,
	input  logic [data_width-1:0] dbg_addr,
	input  logic [1:0]            dbg_width,
	input  logic [data_width-1:0] dbg_wdata,
	input  logic [data_width-1:0] dbg_rd_val,
	input  logic                  dbg_compl,
	output logic                  dbg_ack,
	output logic [data_width-1:0] dbg_rdata,
	output logic                  dbg_en,
	output logic                  dbg_access,
	output logic                  dbg_wr_en,
	output logic [data_width-1:0] dbg_addr_out,
	output logic [1:0]            dbg_width_out,
	output logic [data_width-1:0] dbg_wr_val
);

	localparam logic [1:0] st_idle    = 2'd0;
	localparam logic [1:0] st_access  = 2'd1;
	localparam logic [1:0] st_ack     = 2'd2;
	localparam logic [1:0] st_release = 2'd3;

	logic [1:0] state;

	assign dbg_en     = state != st_idle; // Holds the bus across the whole transfer.
	assign dbg_access = state == st_access;
	assign dbg_ack    = state == st_ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			case (state)
			st_idle:    if (dbg_req) state <= st_access;
			st_access:  if (dbg_compl) state <= st_ack;
			st_ack:     if (!dbg_req) state <= st_release;
			default:    state <= st_idle;
			endcase
		end
	end

	// Request fields and read data.
	always_ff @(posedge clk) begin
		if (state == st_idle && dbg_req) begin
			dbg_wr_en     <= dbg_wr;
			dbg_addr_out  <= dbg_addr;
			dbg_width_out <= dbg_width;
			dbg_wr_val    <= dbg_wdata;
		end
		if (state == st_access && dbg_compl)
			dbg_rdata <= dbg_rd_val;
	end

	a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
		$rose(dbg_ack) |-> dbg_req)
		else $error("dbg_ack raised without a request");

endmodule

// File: verilog/data_ram.sv
`timescale 1ns/1ps

module data_ram import mem_pkg::*; #(
	parameter int ram_words   = 256,
	parameter int wait_states = 2
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [data_width-3:0] d_addr,
	input  logic [3:0]            d_bytesel,
	input  logic                  d_wr_en,
	input  logic [data_width-1:0] d_wr_val,
	input  logic                  d_access,
	output logic [data_width-1:0] d_data,
	output logic                  d_ack,
	output logic                  d_error
);

	localparam int idx_bits = (ram_words > 1) ? $clog2(ram_words) : 1;
	localparam int cnt_bits = (wait_states > 0) ? $clog2(wait_states + 1) : 1;

	localparam logic [1:0] st_idle    = 2'd0;
	localparam logic [1:0] st_wait    = 2'd1;
	localparam logic [1:0] st_respond = 2'd2;

	logic [data_width-1:0] mem [ram_words];
	logic [1:0]            state;
	logic [cnt_bits-1:0]   wait_cnt;
	logic                  access_q;
	logic                  in_range;
	logic [idx_bits-1:0]   word_idx;

	assign word_idx = d_addr[idx_bits-1:0];
	assign in_range = {2'b00, d_addr} < 32'(ram_words);

	assign d_ack   = (state == st_respond) && in_range;
	assign d_error = (state == st_respond) && !in_range;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= st_idle;
			wait_cnt <= '0;
			access_q <= 1'b0;
		end else begin
			access_q <= d_access;
			case (state)
			st_idle: begin
				// A new access needs d_access low the cycle before.
				if (d_access && !access_q) begin
					wait_cnt <= cnt_bits'(1);
					state    <= (wait_states == 0) ? st_respond : st_wait;
				end
			end
			st_wait: begin
				if (wait_cnt == cnt_bits'(wait_states))
					state <= st_respond;
				else
					wait_cnt <= wait_cnt + 1'b1;
			end
			default: state <= st_idle;
			endcase
		end
	end

	// Address is stable for the whole access, so the read lags harmlessly.
	always_ff @(posedge clk) begin
		d_data <= mem[word_idx];
		if (state == st_respond && in_range && d_wr_en) begin
			if (d_bytesel == bytesel_all) begin
				mem[word_idx] <= d_wr_val;
			end else begin
				for (int i = 0; i < 4; i++)
					if (d_bytesel[i])
						mem[word_idx][8*i +: 8] <= d_wr_val[8*i +: 8];
			end
		end
	end

	a_resp_excl: assert property (@(posedge clk) disable iff (rst) !(d_ack && d_error))
		else $error("ack and error together");

endmodule

// File: verilog/mem_stage.sv
`timescale 1ns/1ps

module mem_stage import mem_pkg::*; #(
	parameter int icache_idx_bits = 6
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       load,
	input  logic                       store,
	input  logic [data_width-1:0]      addr,
	input  logic [data_width-1:0]      mdr,
	input  logic                       mem_wr_en,
	input  logic [1:0]                 width,
	input  logic [data_width-1:0]      wr_val,
	input  logic                       update_rd,
	input  logic [3:0]                 rd_sel,
	input  logic                       dbg_en,
	input  logic                       dbg_access,
	input  logic                       dbg_wr_en,
	input  logic [data_width-1:0]      dbg_addr,
	input  logic [1:0]                 dbg_width,
	input  logic [data_width-1:0]      dbg_wr_val,
	input  logic                       cache_instr,
	input  logic [1:0]                 cache_op,
	input  logic [data_width-1:0]      d_data,
	input  logic                       d_ack,
	input  logic                       d_error,
	output logic [data_width-1:0]      reg_wr_val,
	output logic                       update_rd_out,
	output logic [3:0]                 rd_sel_out,
	output logic                       complete,
	output logic                       data_abort,
	output logic [data_width-3:0]      d_addr,
	output logic [3:0]                 d_bytesel,
	output logic                       d_wr_en,
	output logic [data_width-1:0]      d_wr_val,
	output logic                       d_access,
	output logic [data_width-1:0]      dbg_rd_val,
	output logic                       dbg_compl,
	output logic                       busy,
	output logic                       i_inval,
	output logic [icache_idx_bits-1:0] i_idx
);

	logic [data_width-1:0] wr_data;
	logic [1:0]            byte_addr;
	logic [1:0]            mem_width;
	logic [data_width-1:0] mem_rd_val;
	logic                  mem_complete;
	logic                  cache_complete;
	logic                  mem_update_rd;
	logic [3:0]            mem_rd;
	logic                  update_rd_bypass;
	logic [3:0]            rd_sel_bypass;
	logic [data_width-1:0] wr_val_bypass;

	// Debug controller owns the bus while dbg_en is high.
	assign wr_data   = dbg_en ? dbg_wr_val : mdr;
	assign byte_addr = dbg_en ? dbg_addr[1:0] : addr[1:0];
	assign mem_width = dbg_en ? dbg_width : width;
	assign d_addr    = dbg_en ? dbg_addr[data_width-1:2] : addr[data_width-1:2];
	assign d_wr_en   = dbg_en ? dbg_wr_en : mem_wr_en;
	assign d_access  = dbg_en ? dbg_access : (load | store);

	assign mem_complete = d_ack | d_error;
	assign complete     = mem_complete | cache_complete;
	assign data_abort   = d_error;
	assign dbg_rd_val   = mem_rd_val;
	assign dbg_compl    = mem_complete;

	// Loads take the writeback port over the bypassed register-only result.
	assign reg_wr_val    = mem_complete ? mem_rd_val : wr_val_bypass;
	assign rd_sel_out    = mem_complete ? mem_rd : rd_sel_bypass;
	assign update_rd_out = mem_complete ? (mem_update_rd & ~dbg_en & ~d_error) :
		update_rd_bypass;

	assign busy = load | store | update_rd_out;

	assign i_inval = cache_instr && (cache_op == cache_op_inval);
	assign i_idx   = addr[icache_idx_bits-1:0];

	// Lane placement for writes, lane extraction with zero fill for reads.
	always_comb begin
		case (mem_width)
		width_half: begin
			d_bytesel  = 4'b0011 << {byte_addr[1], 1'b0};
			d_wr_val   = wr_data << {byte_addr[1], 4'b0000};
			mem_rd_val = {16'b0, d_data[{byte_addr[1], 4'b0000} +: 16]};
		end
		width_byte: begin
			d_bytesel  = 4'b0001 << byte_addr;
			d_wr_val   = wr_data << {byte_addr, 3'b000};
			mem_rd_val = {24'b0, d_data[{byte_addr, 3'b000} +: 8]};
		end
		default: begin
			d_bytesel  = bytesel_all;
			d_wr_val   = wr_data;
			mem_rd_val = d_data;
		end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			update_rd_bypass <= 1'b0;
			mem_update_rd    <= 1'b0;
			cache_complete   <= 1'b0;
		end else begin
			update_rd_bypass <= update_rd;
			cache_complete   <= cache_instr; // Cache ops finish a cycle later.
			if (load || store)
				mem_update_rd <= load;
		end
	end

	always_ff @(posedge clk) begin
		wr_val_bypass <= wr_val;
		rd_sel_bypass <= rd_sel;
		if (load)
			mem_rd <= rd_sel; // Destination held for the whole access.
	end

	a_load_store_excl: assert property (@(posedge clk) disable iff (rst) !(load && store))
		else $error("load and store both high");

endmodule

// File: verilog/mem_pkg.sv
package mem_pkg;

	// Bus and register width.
	localparam int data_width = 32;

	// Access width codes. Any unlisted code acts as a word.
	localparam logic [1:0] width_byte = 2'd0;
	localparam logic [1:0] width_half = 2'd1;
	localparam logic [1:0] width_word = 2'd2;

	localparam logic [1:0] cache_op_inval = 2'd0; // Invalidate one icache line.

	localparam logic [3:0] bytesel_all = 4'b1111;

endpackage
